//--- common/guard_settings.svh
// Sizing macros for the guarded read port: table depth, bus widths, counter and prescaler
`ifndef GUARD_SETTINGS_SVH
`define GUARD_SETTINGS_SVH

// Table entries and most reads in flight
`define GUARD_TXNS 4

// Slave side id width, top bit names the source master
`define GUARD_ID_W 4

// Burst length field, a burst has len+1 beats
`define GUARD_LEN_W 3

`define GUARD_DATA_W 16

// Age and limit counters
`define GUARD_CNT_W 10

// Clock cycles per age tick
`define GUARD_PRESCALE 2

`endif

//--- common/guard_pkg.sv
// Package with the read bus field types and the transaction table entry type

`include "guard_settings.svh"

package guard_pkg;

  // Index width of the table, at least one bit
  localparam int TblIdxW = (`GUARD_TXNS > 1) ? $clog2(`GUARD_TXNS) : 1;

  // Slave side id with the master number on top
  typedef logic [`GUARD_ID_W-1:0] id_t;

  // Master side id, one bit narrower
  typedef logic [`GUARD_ID_W-2:0] mst_id_t;

  typedef logic [`GUARD_LEN_W-1:0] len_t;

  typedef logic [`GUARD_DATA_W-1:0] data_t;

  // Shared by age and limit
  typedef logic [`GUARD_CNT_W-1:0] cnt_t;

  typedef logic [TblIdxW-1:0] tbl_idx_t;

  // One outstanding read
  typedef struct packed {
    logic valid;
    id_t  id;
    // Beats still owed, minus one
    len_t beats;
    // Budget in ticks for the whole burst
    cnt_t limit;
    // Ticks since address acceptance
    cnt_t age;
  } txn_entry_t;

endpackage

//--- hdl/rd_arbiter.sv
// Round-robin read address arbiter for two masters with data routing by id tag
`timescale 1ns/1ns

module rd_arbiter (
  input  logic              clk_i,
  input  logic              reset_i,
  // Master 0
  input  logic              m0_ar_valid_i,
  output logic              m0_ar_ready_o,
  input  guard_pkg::mst_id_t m0_ar_id_i,
  input  guard_pkg::len_t   m0_ar_len_i,
  output logic              m0_r_valid_o,
  input  logic              m0_r_ready_i,
  output guard_pkg::mst_id_t m0_r_id_o,
  output guard_pkg::data_t  m0_r_data_o,
  output logic              m0_r_last_o,
  // Master 1
  input  logic              m1_ar_valid_i,
  output logic              m1_ar_ready_o,
  input  guard_pkg::mst_id_t m1_ar_id_i,
  input  guard_pkg::len_t   m1_ar_len_i,
  output logic              m1_r_valid_o,
  input  logic              m1_r_ready_i,
  output guard_pkg::mst_id_t m1_r_id_o,
  output guard_pkg::data_t  m1_r_data_o,
  output logic              m1_r_last_o,
  // Merged address channel toward the guard
  output logic              arb_ar_valid_o,
  input  logic              arb_ar_ready_i,
  output guard_pkg::id_t    arb_ar_id_o,
  output guard_pkg::len_t   arb_ar_len_o,
  // Slave data channel
  input  logic              slv_r_valid_i,
  output logic              slv_r_ready_o,
  input  guard_pkg::id_t    slv_r_id_i,
  input  guard_pkg::data_t  slv_r_data_i,
  input  logic              slv_r_last_i
);

  localparam int IdW = $bits(guard_pkg::id_t);

  logic prio_q;
  logic lock_q;
  logic grant_q;
  logic sel;
  logic r_sel;

  // Held grant wins while an address waits, else round robin
  assign sel = lock_q ? grant_q : (m1_ar_valid_i && (!m0_ar_valid_i || prio_q));

  assign arb_ar_valid_o = sel ? m1_ar_valid_i : m0_ar_valid_i;
  assign arb_ar_id_o    = {sel, (sel ? m1_ar_id_i : m0_ar_id_i)};
  assign arb_ar_len_o   = sel ? m1_ar_len_i : m0_ar_len_i;
  assign m0_ar_ready_o  = !sel && arb_ar_ready_i;
  assign m1_ar_ready_o  = sel && arb_ar_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q  <= 1'b0;
      lock_q  <= 1'b0;
      grant_q <= 1'b0;
    end else if (arb_ar_valid_o && arb_ar_ready_i) begin
      // Other master goes first next time
      prio_q <= !sel;
      lock_q <= 1'b0;
    end else if (arb_ar_valid_o) begin
      lock_q  <= 1'b1;
      grant_q <= sel;
    end
  end

  // Data goes back to the master named by the top id bit
  assign r_sel = slv_r_id_i[IdW-1];

  assign m0_r_valid_o  = slv_r_valid_i && !r_sel;
  assign m1_r_valid_o  = slv_r_valid_i && r_sel;
  assign m0_r_id_o     = slv_r_id_i[IdW-2:0];
  assign m1_r_id_o     = slv_r_id_i[IdW-2:0];
  assign m0_r_data_o   = slv_r_data_i;
  assign m1_r_data_o   = slv_r_data_i;
  assign m0_r_last_o   = slv_r_last_i;
  assign m1_r_last_o   = slv_r_last_i;
  assign slv_r_ready_o = r_sel ? m1_r_ready_i : m0_r_ready_i;

endmodule

//--- read_guard/txn_table.sv
// Outstanding read table with free slot search, id lookup, age counters and overrun flag
`timescale 1ns/1ns

`include "guard_settings.svh"

module txn_table (
  input  logic               clk_i,
  input  logic               reset_i,
  // New transaction
  input  logic               alloc_i,
  input  guard_pkg::id_t     alloc_id_i,
  input  guard_pkg::len_t    alloc_len_i,
  input  guard_pkg::cnt_t    budget_i,
  // Data beat seen at the slave
  input  logic               beat_i,
  input  guard_pkg::id_t     beat_id_i,
  input  logic               beat_last_i,
  input  logic               tick_i,
  input  logic               flush_i,
  output logic               full_o,
  output logic               id_busy_o,
  input  guard_pkg::id_t     lookup_id_i,
  output logic               overrun_o
);

  localparam int ProdW = `GUARD_CNT_W + `GUARD_LEN_W + 1;

  guard_pkg::txn_entry_t tbl_q [`GUARD_TXNS];

  guard_pkg::tbl_idx_t     free_idx;
  logic [`GUARD_TXNS-1:0]  beat_hit;
  logic [`GUARD_LEN_W:0]   beats_total;
  logic [ProdW-1:0]        limit_full;
  guard_pkg::cnt_t         limit_new;

  // Limit is beats times budget, saturated to the counter range
  assign beats_total = {1'b0, alloc_len_i} + 1'b1;
  assign limit_full  = beats_total * budget_i;
  assign limit_new   = (|limit_full[ProdW-1:`GUARD_CNT_W]) ? '1 :
                       limit_full[`GUARD_CNT_W-1:0];

  // Lowest free slot
  always_comb begin
    free_idx = '0;
    for (int i = `GUARD_TXNS - 1; i >= 0; i--) begin
      if (!tbl_q[i].valid) begin
        free_idx = guard_pkg::tbl_idx_t'(i);
      end
    end
  end

  always_comb begin
    full_o    = 1'b1;
    id_busy_o = 1'b0;
    overrun_o = 1'b0;
    for (int i = 0; i < `GUARD_TXNS; i++) begin
      beat_hit[i] = beat_i && tbl_q[i].valid && (tbl_q[i].id == beat_id_i);
      if (!tbl_q[i].valid) begin
        full_o = 1'b0;
      end
      if (tbl_q[i].valid && (tbl_q[i].id == lookup_id_i)) begin
        id_busy_o = 1'b1;
      end
      // Strictly past the budget
      if (tbl_q[i].valid && (tbl_q[i].age > tbl_q[i].limit)) begin
        overrun_o = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < `GUARD_TXNS; i++) begin
      if (reset_i) begin
        tbl_q[i].valid <= 1'b0;
      end else if (alloc_i && (free_idx == guard_pkg::tbl_idx_t'(i))) begin
        // New entry starts at age zero and skips this tick
        tbl_q[i].valid <= 1'b1;
        tbl_q[i].id    <= alloc_id_i;
        tbl_q[i].beats <= alloc_len_i;
        tbl_q[i].limit <= limit_new;
        tbl_q[i].age   <= '0;
      end else if (flush_i) begin
        tbl_q[i].valid <= 1'b0;
      end else if (tbl_q[i].valid) begin
        if (beat_hit[i] && beat_last_i) begin
          tbl_q[i].valid <= 1'b0;
        end else begin
          if (beat_hit[i] && (tbl_q[i].beats != '0)) begin
            tbl_q[i].beats <= tbl_q[i].beats - 1'b1;
          end
          // Age holds at its top value
          if (tick_i && (tbl_q[i].age != '1)) begin
            tbl_q[i].age <= tbl_q[i].age + 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- read_guard/read_guard.sv
// Read guard with address gating, prescaler, table control and the interrupt state
`timescale 1ns/1ns

`include "guard_settings.svh"

module read_guard (
  input  logic            clk_i,
  input  logic            reset_i,
  // Address from the arbiter
  input  logic            arb_ar_valid_i,
  output logic            arb_ar_ready_o,
  input  guard_pkg::id_t  arb_ar_id_i,
  input  guard_pkg::len_t arb_ar_len_i,
  // Address to the slave
  output logic            slv_ar_valid_o,
  input  logic            slv_ar_ready_i,
  output guard_pkg::id_t  slv_ar_id_o,
  output guard_pkg::len_t slv_ar_len_o,
  // Observed data handshake
  input  logic            slv_r_valid_i,
  input  logic            slv_r_ready_i,
  input  guard_pkg::id_t  slv_r_id_i,
  input  logic            slv_r_last_i,
  // Control
  input  guard_pkg::cnt_t budget_i,
  input  logic            reset_clear_i,
  output logic            irq_o,
  output logic            reset_req_o
);

  localparam int PsW = (`GUARD_PRESCALE > 1) ? $clog2(`GUARD_PRESCALE) : 1;
  localparam logic [PsW-1:0] PsLast = PsW'(`GUARD_PRESCALE - 1);

  logic [PsW-1:0] ps_q;
  logic           tick;
  logic           full;
  logic           id_busy;
  logic           overrun;
  logic           gate_open;
  logic           alloc;
  logic           beat;
  logic           trip_q;

  // Free running tick divider
  assign tick = (ps_q == PsLast);

  always_ff @(posedge clk_i) begin
    if (reset_i || tick) begin
      ps_q <= '0;
    end else begin
      ps_q <= ps_q + 1'b1;
    end
  end

  // Address passes only with a free slot, an idle id and no pending trip
  assign gate_open      = !full && !id_busy && !trip_q;
  assign slv_ar_valid_o = arb_ar_valid_i && gate_open;
  assign arb_ar_ready_o = slv_ar_ready_i && gate_open;
  assign slv_ar_id_o    = arb_ar_id_i;
  assign slv_ar_len_o   = arb_ar_len_i;

  assign alloc = slv_ar_valid_o && slv_ar_ready_i;
  assign beat  = slv_r_valid_i && slv_r_ready_i;

  txn_table i_txn_table (
    .clk_i       ( clk_i         ),
    .reset_i     ( reset_i       ),
    .alloc_i     ( alloc         ),
    .alloc_id_i  ( arb_ar_id_i   ),
    .alloc_len_i ( arb_ar_len_i  ),
    .budget_i    ( budget_i      ),
    .beat_i      ( beat          ),
    .beat_id_i   ( slv_r_id_i    ),
    .beat_last_i ( slv_r_last_i  ),
    .tick_i      ( tick          ),
    .flush_i     ( reset_clear_i ),
    .full_o      ( full          ),
    .id_busy_o   ( id_busy       ),
    .lookup_id_i ( arb_ar_id_i   ),
    .overrun_o   ( overrun       )
  );

  // Sticky until software clears it
  always_ff @(posedge clk_i) begin
    if (reset_i || reset_clear_i) begin
      trip_q <= 1'b0;
    end else if (overrun) begin
      trip_q <= 1'b1;
    end
  end

  assign irq_o       = trip_q;
  assign reset_req_o = trip_q;

endmodule

//--- hdl/guarded_read_top.sv
// Top level of the guarded read port joining arbiter, read guard and slave bus
`timescale 1ns/1ns

module guarded_read_top (
  input  logic               clk_i,
  input  logic               reset_i,
  // Master 0
  input  logic               m0_ar_valid_i,
  output logic               m0_ar_ready_o,
  input  guard_pkg::mst_id_t m0_ar_id_i,
  input  guard_pkg::len_t    m0_ar_len_i,
  output logic               m0_r_valid_o,
  input  logic               m0_r_ready_i,
  output guard_pkg::mst_id_t m0_r_id_o,
  output guard_pkg::data_t   m0_r_data_o,
  output logic               m0_r_last_o,
  // Master 1
  input  logic               m1_ar_valid_i,
  output logic               m1_ar_ready_o,
  input  guard_pkg::mst_id_t m1_ar_id_i,
  input  guard_pkg::len_t    m1_ar_len_i,
  output logic               m1_r_valid_o,
  input  logic               m1_r_ready_i,
  output guard_pkg::mst_id_t m1_r_id_o,
  output guard_pkg::data_t   m1_r_data_o,
  output logic               m1_r_last_o,
  // Slave bus
  output logic               slv_ar_valid_o,
  input  logic               slv_ar_ready_i,
  output guard_pkg::id_t     slv_ar_id_o,
  output guard_pkg::len_t    slv_ar_len_o,
  input  logic               slv_r_valid_i,
  output logic               slv_r_ready_o,
  input  guard_pkg::id_t     slv_r_id_i,
  input  guard_pkg::data_t   slv_r_data_i,
  input  logic               slv_r_last_i,
  // Control
  input  guard_pkg::cnt_t    budget_i,
  input  logic               reset_clear_i,
  output logic               irq_o,
  output logic               reset_req_o
);

  logic            arb_ar_valid;
  logic            arb_ar_ready;
  guard_pkg::id_t  arb_ar_id;
  guard_pkg::len_t arb_ar_len;

  rd_arbiter i_rd_arbiter (
    .clk_i          ( clk_i         ),
    .reset_i        ( reset_i       ),
    .m0_ar_valid_i  ( m0_ar_valid_i ),
    .m0_ar_ready_o  ( m0_ar_ready_o ),
    .m0_ar_id_i     ( m0_ar_id_i    ),
    .m0_ar_len_i    ( m0_ar_len_i   ),
    .m0_r_valid_o   ( m0_r_valid_o  ),
    .m0_r_ready_i   ( m0_r_ready_i  ),
    .m0_r_id_o      ( m0_r_id_o     ),
    .m0_r_data_o    ( m0_r_data_o   ),
    .m0_r_last_o    ( m0_r_last_o   ),
    .m1_ar_valid_i  ( m1_ar_valid_i ),
    .m1_ar_ready_o  ( m1_ar_ready_o ),
    .m1_ar_id_i     ( m1_ar_id_i    ),
    .m1_ar_len_i    ( m1_ar_len_i   ),
    .m1_r_valid_o   ( m1_r_valid_o  ),
    .m1_r_ready_i   ( m1_r_ready_i  ),
    .m1_r_id_o      ( m1_r_id_o     ),
    .m1_r_data_o    ( m1_r_data_o   ),
    .m1_r_last_o    ( m1_r_last_o   ),
    .arb_ar_valid_o ( arb_ar_valid  ),
    .arb_ar_ready_i ( arb_ar_ready  ),
    .arb_ar_id_o    ( arb_ar_id     ),
    .arb_ar_len_o   ( arb_ar_len    ),
    .slv_r_valid_i  ( slv_r_valid_i ),
    .slv_r_ready_o  ( slv_r_ready_o ),
    .slv_r_id_i     ( slv_r_id_i    ),
    .slv_r_data_i   ( slv_r_data_i  ),
    .slv_r_last_i   ( slv_r_last_i  )
  );

  read_guard i_read_guard (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .arb_ar_valid_i ( arb_ar_valid   ),
    .arb_ar_ready_o ( arb_ar_ready   ),
    .arb_ar_id_i    ( arb_ar_id      ),
    .arb_ar_len_i   ( arb_ar_len     ),
    .slv_ar_valid_o ( slv_ar_valid_o ),
    .slv_ar_ready_i ( slv_ar_ready_i ),
    .slv_ar_id_o    ( slv_ar_id_o    ),
    .slv_ar_len_o   ( slv_ar_len_o   ),
    .slv_r_valid_i  ( slv_r_valid_i  ),
    .slv_r_ready_i  ( slv_r_ready_o  ),
    .slv_r_id_i     ( slv_r_id_i     ),
    .slv_r_last_i   ( slv_r_last_i   ),
    .budget_i       ( budget_i       ),
    .reset_clear_i  ( reset_clear_i  ),
    .irq_o          ( irq_o          ),
    .reset_req_o    ( reset_req_o    )
  );

endmodule

//--- verification/guard_chk.sv
// Bound assertions on the read guard for address blocking, sticky interrupt and beat ids
`timescale 1ns/1ns

module guard_chk (
  input logic           clk_i,
  input logic           reset_i,
  input logic           slv_ar_valid_o,
  input logic           slv_ar_ready_i,
  input guard_pkg::id_t slv_ar_id_o,
  input logic           slv_r_valid_i,
  input logic           slv_r_ready_i,
  input guard_pkg::id_t slv_r_id_i,
  input logic           slv_r_last_i,
  input logic           reset_clear_i,
  input logic           irq_o,
  input logic           reset_req_o
);

  // Ids with an accepted address and no last beat yet
  logic [15:0] open_q;

  always_ff @(posedge clk_i) begin
    if (reset_i || reset_clear_i) begin
      open_q <= '0;
    end else begin
      if (slv_r_valid_i && slv_r_ready_i && slv_r_last_i) begin
        open_q[slv_r_id_i] <= 1'b0;
      end
      if (slv_ar_valid_o && slv_ar_ready_i) begin
        open_q[slv_ar_id_o] <= 1'b1;
      end
    end
  end

  no_addr_in_trip: assert property (@(posedge clk_i) disable iff (reset_i)
    reset_req_o |-> !slv_ar_valid_o)
    else $error("address issued while a reset request is pending");

  irq_sticky: assert property (@(posedge clk_i) disable iff (reset_i)
    (irq_o && !reset_clear_i) |=> irq_o)
    else $error("interrupt dropped without a clear");

  last_has_entry: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_r_valid_i && slv_r_ready_i && slv_r_last_i) |-> open_q[slv_r_id_i])
    else $error("last beat for an id with no outstanding read");

endmodule

bind read_guard guard_chk i_guard_chk (.*);

//--- verification/guarded_read_tb.sv
// Testbench for the guarded read port with random masters, slave model and reference checks
`timescale 1ns/1ns

`include "guard_settings.svh"

module guarded_read_tb;

  localparam int NumRun    = 60;
  localparam int NumFresh  = 20;
  localparam int MaxBeats  = 8;
  localparam int MaxDelay  = 8;
  localparam int NumTotal  = NumRun + NumFresh + 2;
  localparam int CycLimit  = 4 * (NumTotal * (MaxBeats + MaxDelay));
  localparam int BigBudget = 100;
  localparam int TripBudget = 3;

  logic               clk_i;
  logic               reset_i;
  logic               ar_valid [2];
  logic               ar_ready [2];
  guard_pkg::mst_id_t ar_id [2];
  guard_pkg::len_t    ar_len [2];
  logic               r_valid [2];
  logic               r_ready [2];
  guard_pkg::mst_id_t r_id [2];
  guard_pkg::data_t   r_data [2];
  logic               r_last [2];
  logic               slv_ar_valid_o;
  logic               slv_ar_ready_i;
  guard_pkg::id_t     slv_ar_id_o;
  guard_pkg::len_t    slv_ar_len_o;
  logic               slv_r_valid_i;
  logic               slv_r_ready_o;
  guard_pkg::id_t     slv_r_id_i;
  guard_pkg::data_t   slv_r_data_i;
  logic               slv_r_last_i;
  guard_pkg::cnt_t    budget_i;
  logic               reset_clear_i;
  logic               irq_o;
  logic               reset_req_o;

  integer seed;
  int     cyc;
  int     issue_left [2];
  int     wait_cnt [2];
  bit     ar_done [2];
  bit     no_irq;
  bit     hold_next;
  int     held_id;
  int     held_len;
  int     acc_cyc;
  // Slave model state per slave id
  bit     sbusy [16];
  bit     shold [16];
  int     slen [16];
  int     sbeat [16];
  int     sdelay [16];
  int     outstanding;
  bit     pres;
  int     pres_id;

  guarded_read_top guarded_read_top_i (
    .clk_i (clk_i), .reset_i (reset_i),
    .m0_ar_valid_i (ar_valid[0]), .m0_ar_ready_o (ar_ready[0]),
    .m0_ar_id_i (ar_id[0]), .m0_ar_len_i (ar_len[0]),
    .m0_r_valid_o (r_valid[0]), .m0_r_ready_i (r_ready[0]),
    .m0_r_id_o (r_id[0]), .m0_r_data_o (r_data[0]), .m0_r_last_o (r_last[0]),
    .m1_ar_valid_i (ar_valid[1]), .m1_ar_ready_o (ar_ready[1]),
    .m1_ar_id_i (ar_id[1]), .m1_ar_len_i (ar_len[1]),
    .m1_r_valid_o (r_valid[1]), .m1_r_ready_i (r_ready[1]),
    .m1_r_id_o (r_id[1]), .m1_r_data_o (r_data[1]), .m1_r_last_o (r_last[1]),
    .slv_ar_valid_o (slv_ar_valid_o), .slv_ar_ready_i (slv_ar_ready_i),
    .slv_ar_id_o (slv_ar_id_o), .slv_ar_len_o (slv_ar_len_o),
    .slv_r_valid_i (slv_r_valid_i), .slv_r_ready_o (slv_r_ready_o),
    .slv_r_id_i (slv_r_id_i), .slv_r_data_i (slv_r_data_i), .slv_r_last_i (slv_r_last_i),
    .budget_i (budget_i), .reset_clear_i (reset_clear_i),
    .irq_o (irq_o), .reset_req_o (reset_req_o)
  );

  task automatic fail_msg(input string what);
    $display("Failure at %0t: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_id(input string name, input guard_pkg::mst_id_t act,
                          input guard_pkg::mst_id_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_len(input string name, input guard_pkg::len_t act,
                           input guard_pkg::len_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_data(input string name, input guard_pkg::data_t act,
                            input guard_pkg::data_t exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_last(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_ready(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_irq(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("** Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // Monitor and reference model, sampled on the rising edge
  always @(posedge clk_i) begin
    bit acc [2];
    int sid;
    int m;
    cyc++;
    if (cyc > CycLimit) begin
      fail_msg("run did not finish within the cycle limit");
    end
    if (!reset_i) begin
      if (no_irq) begin
        check_irq("irq_o", irq_o, 1'b0);
        check_irq("reset_req_o", reset_req_o, 1'b0);
      end
      if (reset_req_o && slv_ar_valid_o) begin
        fail_msg("address reached the slave during a reset request");
      end
      for (int i = 0; i < 2; i++) begin
        acc[i] = ar_valid[i] && ar_ready[i];
      end
      for (int i = 0; i < 2; i++) begin
        if (!ar_valid[i] || acc[i]) begin
          wait_cnt[i] = 0;
        end else if (acc[1-i]) begin
          wait_cnt[i]++;
          if (wait_cnt[i] > 2) begin
            fail_msg("master starved by the arbiter");
          end
        end
      end
      if (slv_ar_valid_o && slv_ar_ready_i) begin
        sid = int'(slv_ar_id_o);
        m = sid >> 3;
        if (!acc[m]) begin
          fail_msg("slave address without a matching master handshake");
        end
        check_id("slv_ar_id_o", slv_ar_id_o[2:0], ar_id[m]);
        check_len("slv_ar_len_o", slv_ar_len_o, ar_len[m]);
        if (sbusy[sid]) begin
          fail_msg("slave id issued again while still outstanding");
        end
        sbusy[sid]  = 1'b1;
        slen[sid]   = int'(ar_len[m]);
        sbeat[sid]  = 0;
        sdelay[sid] = $random(seed) & 7;
        shold[sid]  = hold_next;
        if (hold_next) begin
          held_id  = sid;
          held_len = slen[sid];
          acc_cyc  = cyc;
        end
        hold_next = 1'b0;
        ar_done[m] = 1'b1;
        outstanding++;
        if (outstanding > `GUARD_TXNS) begin
          fail_msg("more reads in flight than table entries");
        end
      end else if (acc[0] || acc[1]) begin
        fail_msg("master address accepted without reaching the slave");
      end
      for (int j = 0; j < 16; j++) begin
        if (sdelay[j] > 0) begin
          sdelay[j]--;
        end
      end
      // Slave ready follows the ready of the master that owns the beat
      if (slv_r_valid_i) begin
        m = pres_id >> 3;
        check_ready("slv_r_ready_o", slv_r_ready_o, r_ready[m]);
      end
      if (slv_r_valid_i && slv_r_ready_o) begin
        sid = pres_id;
        m = sid >> 3;
        if (!r_valid[m] || r_valid[1-m]) begin
          fail_msg("data beat routed to the wrong master");
        end
        check_id("r_id_o", r_id[m], guard_pkg::mst_id_t'(sid & 7));
        check_data("r_data_o", r_data[m], guard_pkg::data_t'(sid * 16 + sbeat[sid]));
        check_last("r_last_o", r_last[m], sbeat[sid] == slen[sid]);
        if (sbeat[sid] == slen[sid]) begin
          sbusy[sid] = 1'b0;
          outstanding--;
        end else begin
          sbeat[sid]++;
        end
        pres = 1'b0;
      end
    end
  end

  // Masters and slave drive on the falling edge
  always @(negedge clk_i) begin
    int off;
    int j;
    if (!reset_i) begin
      for (int i = 0; i < 2; i++) begin
        if (ar_done[i]) begin
          ar_valid[i] = 1'b0;
          ar_done[i]  = 1'b0;
        end
        if (!ar_valid[i] && issue_left[i] > 0 && ($random(seed) & 1)) begin
          ar_valid[i] = 1'b1;
          ar_id[i]    = guard_pkg::mst_id_t'($random(seed));
          ar_len[i]   = guard_pkg::len_t'($random(seed));
          issue_left[i]--;
        end
        r_ready[i] = ($random(seed) & 3) != 0;
      end
      slv_ar_ready_i = ($random(seed) & 3) != 0;
      if (!pres) begin
        off = $random(seed) & 15;
        for (int i = 0; i < 16; i++) begin
          j = (off + i) & 15;
          if (!pres && sbusy[j] && !shold[j] && sdelay[j] == 0) begin
            pres    = 1'b1;
            pres_id = j;
          end
        end
      end
      slv_r_valid_i = pres;
      slv_r_id_i    = guard_pkg::id_t'(pres_id);
      slv_r_data_i  = guard_pkg::data_t'(pres_id * 16 + sbeat[pres_id]);
      slv_r_last_i  = pres && (sbeat[pres_id] == slen[pres_id]);
    end
  end

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (issue_left[0] > 0 || issue_left[1] > 0 || ar_valid[0] || ar_valid[1] ||
               outstanding > 0);
  endtask

  initial begin
    seed = 5;
    reset_i = 1'b1;
    reset_clear_i = 1'b0;
    budget_i = guard_pkg::cnt_t'(BigBudget);
    slv_ar_ready_i = 1'b0;
    slv_r_valid_i = 1'b0;
    slv_r_id_i = '0;
    slv_r_data_i = '0;
    slv_r_last_i = 1'b0;
    for (int i = 0; i < 2; i++) begin
      ar_valid[i] = 1'b0;
      ar_id[i] = '0;
      ar_len[i] = '0;
      r_ready[i] = 1'b0;
    end
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_irq("irq_o", irq_o, 1'b0);
    // Random traffic with a generous budget
    no_irq = 1'b1;
    issue_left[0] = NumRun / 2;
    issue_left[1] = NumRun / 2;
    wait_idle();
    // One withheld read trips the guard
    no_irq = 1'b0;
    budget_i = guard_pkg::cnt_t'(TripBudget);
    hold_next = 1'b1;
    issue_left[0] = 1;
    do begin
      @(negedge clk_i);
    end while (!irq_o);
    check_irq("reset_req_o", reset_req_o, 1'b1);
    if (cyc - acc_cyc < (held_len + 1) * TripBudget * `GUARD_PRESCALE) begin
      fail_msg("interrupt rose before the budget ran out");
    end
    issue_left[1] = 1;
    repeat (20) begin
      @(negedge clk_i);
      check_irq("irq_o", irq_o, 1'b1);
      check_irq("reset_req_o", reset_req_o, 1'b1);
    end
    reset_clear_i = 1'b1;
    @(negedge clk_i);
    reset_clear_i = 1'b0;
    sbusy[held_id] = 1'b0;
    shold[held_id] = 1'b0;
    outstanding--;
    check_irq("irq_o", irq_o, 1'b0);
    check_irq("reset_req_o", reset_req_o, 1'b0);
    budget_i = guard_pkg::cnt_t'(BigBudget);
    no_irq = 1'b1;
    issue_left[0] = NumFresh / 2;
    issue_left[1] = NumFresh / 2;
    wait_idle();
    $display("TEST OK");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+common
common/guard_pkg.sv
hdl/rd_arbiter.sv
read_guard/txn_table.sv
read_guard/read_guard.sv
hdl/guarded_read_top.sv
verification/guard_chk.sv
verification/guarded_read_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	  --top-module guarded_read_tb -o guarded_read_sim
	./obj_dir/guarded_read_sim 2>&1 | tee sim.log
	! grep -q "TEST FAILED" sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
